/* hw/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // data path width of the integer core.
    parameter int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    // operations after decode. Anything not in the supported subset becomes op_nop.
    typedef enum logic [3:0] {
        op_nop,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_addi,
        op_lw,
        op_sw,
        op_ebreak
    } op_e;

    // where an execute operand comes from.
    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem,
        fwd_wb
    } fwd_e;

endpackage

`default_nettype wire

/* hw/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
    import rv_pkg::*;
#(
    parameter int imem_depth = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load_en,
    input  logic [$clog2(imem_depth)-1:0] load_addr,
    input  logic [xlen-1:0]               load_data,
    input  logic                          run,
    input  logic                          stall,
    input  logic                          halt,
    output logic                          if_valid,
    output logic [xlen-1:0]               if_instr
);

    localparam int aw = $clog2(imem_depth);

    logic [xlen-1:0] imem [imem_depth];
    logic [aw-1:0]   pc;
    logic [aw-1:0]   fetch_pc;
    logic            run_q;
    logic            start;
    logic            issue;

    // the first cycle of run always fetches from word 0.
    assign start    = run && !run_q;
    assign fetch_pc = start ? '0 : pc;
    assign issue    = run && !stall && !halt;

    always_ff @(posedge clk) begin
        if (load_en && !run) begin
            imem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            run_q    <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            run_q <= run;
            if (issue) begin
                pc       <= fetch_pc + 1'b1;
                if_valid <= 1'b1;
            end else if (!stall) begin
                if_valid <= 1'b0;
            end
        end
    end

    // a stall leaves the IF/ID word in place so decode sees it again.
    always_ff @(posedge clk) begin
        if (issue) begin
            if_instr <= imem[fetch_pc];
        end
    end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  reg_addr_t       rs1,
    input  reg_addr_t       rs2,
    input  logic            we,
    input  reg_addr_t       wd_addr,
    input  logic [xlen-1:0] wd_data,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wd_addr != '0) begin
            regs[wd_addr] <= wd_data;
        end
    end

    // the value being written this cycle is passed straight to a matching read.
    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
        end else if (we && wd_addr == rs1) begin
            rs1_data = wd_data;
        end else begin
            rs1_data = regs[rs1];
        end
        if (rs2 == '0) begin
            rs2_data = '0;
        end else if (we && wd_addr == rs2) begin
            rs2_data = wd_data;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit
    import rv_pkg::*;
(
    input  logic      if_valid,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      uses_rs2,
    input  logic      ex_is_load,
    input  reg_addr_t ex_rd,
    output logic      stall
);

    logic rs1_hit;
    logic rs2_hit;

    // a load result only exists after the memory stage, so its consumer
    // in decode must wait one cycle. Every other dependency is forwarded.
    assign rs1_hit = rs1 == ex_rd;
    assign rs2_hit = uses_rs2 && (rs2 == ex_rd);

    always_comb begin
        stall = 1'b0;
        if (if_valid && ex_is_load && ex_rd != '0) begin
            stall = rs1_hit || rs2_hit;
        end
    end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            if_valid,
    input  logic [xlen-1:0] if_instr,
    input  logic            wb_valid,
    input  reg_addr_t       wb_rd,
    input  logic [xlen-1:0] wb_data,
    output logic            stall,
    output logic            halt,
    output logic            id_valid,
    output op_e             id_op,
    output reg_addr_t       id_rd,
    output reg_addr_t       id_rs1,
    output reg_addr_t       id_rs2,
    output logic [xlen-1:0] id_rs1_data,
    output logic [xlen-1:0] id_rs2_data,
    output logic [xlen-1:0] id_imm
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    op_e             dec_op;
    reg_addr_t       dec_rd;
    reg_addr_t       rs1;
    reg_addr_t       rs2;
    logic [xlen-1:0] dec_imm;
    logic            uses_rs2;
    logic            writes_rd;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            ex_is_load;
    logic            halt_q;

    assign opcode = if_instr[6:0];
    assign funct3 = if_instr[14:12];
    assign funct7 = if_instr[31:25];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];

    always_comb begin
        dec_op = op_nop;
        case (opcode)
            7'b0110011: begin
                if (funct7 == 7'b0000000 && funct3 == 3'b000) begin
                    dec_op = op_add;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec_op = op_sub;
                end else if (funct7 == 7'b0000000 && funct3 == 3'b111) begin
                    dec_op = op_and;
                end else if (funct7 == 7'b0000000 && funct3 == 3'b110) begin
                    dec_op = op_or;
                end
            end
            7'b0010011: if (funct3 == 3'b000) dec_op = op_addi;
            7'b0000011: if (funct3 == 3'b010) dec_op = op_lw;
            7'b0100011: if (funct3 == 3'b010) dec_op = op_sw;
            7'b1110011: if (if_instr == 32'h0010_0073) dec_op = op_ebreak;
            default: dec_op = op_nop;
        endcase
    end

    assign uses_rs2  = dec_op inside {op_add, op_sub, op_and, op_or, op_sw};
    assign writes_rd = dec_op inside {op_add, op_sub, op_and, op_or, op_addi, op_lw};

    // instructions without a destination carry rd zero, so nothing forwards from them.
    assign dec_rd  = writes_rd ? if_instr[11:7] : '0;
    assign dec_imm = (dec_op == op_sw) ?
                     {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]} :
                     {{20{if_instr[31]}}, if_instr[31:20]};

    reg_file i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .we       (wb_valid),
        .wd_addr  (wb_rd),
        .wd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // the instruction now in execute is the one held in ID/EX.
    assign ex_is_load = id_valid && id_op == op_lw;

    hazard_unit i_hazard_unit (
        .if_valid   (if_valid),
        .rs1        (rs1),
        .rs2        (rs2),
        .uses_rs2   (uses_rs2),
        .ex_is_load (ex_is_load),
        .ex_rd      (id_rd),
        .stall      (stall)
    );

    // fetch must stop as soon as EBREAK shows up, and stay stopped.
    assign halt = halt_q || (if_valid && dec_op == op_ebreak);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            halt_q   <= 1'b0;
        end else begin
            id_valid <= if_valid && !stall;
            if (if_valid && dec_op == op_ebreak) begin
                halt_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        id_op       <= dec_op;
        id_rd       <= dec_rd;
        id_rs1      <= rs1;
        id_rs2      <= rs2;
        id_rs1_data <= rs1_data;
        id_rs2_data <= rs2_data;
        id_imm      <= dec_imm;
    end

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            id_valid,
    input  op_e             id_op,
    input  reg_addr_t       id_rd,
    input  reg_addr_t       id_rs1,
    input  reg_addr_t       id_rs2,
    input  logic [xlen-1:0] id_rs1_data,
    input  logic [xlen-1:0] id_rs2_data,
    input  logic [xlen-1:0] id_imm,
    input  logic            wb_valid,
    input  reg_addr_t       wb_rd,
    input  logic [xlen-1:0] wb_data,
    output logic            ex_valid,
    output op_e             ex_op,
    output reg_addr_t       ex_rd,
    output logic [xlen-1:0] ex_result,
    output logic [xlen-1:0] ex_store_data
);

    fwd_e            rs1_sel;
    fwd_e            rs2_sel;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;

    // the younger result in EX/MEM wins over writeback. A load in EX/MEM still
    // holds its address there, and the load-use stall keeps it from being needed.
    function automatic fwd_e fwd_pick(input reg_addr_t rs);
        fwd_e sel;
        sel = fwd_reg;
        if (ex_valid && ex_rd != '0 && ex_rd == rs && ex_op != op_lw) begin
            sel = fwd_mem;
        end else if (wb_valid && wb_rd != '0 && wb_rd == rs) begin
            sel = fwd_wb;
        end
        return sel;
    endfunction

    function automatic logic [xlen-1:0] fwd_value(input fwd_e sel, input logic [xlen-1:0] rd);
        logic [xlen-1:0] value;
        case (sel)
            fwd_mem: value = ex_result;
            fwd_wb:  value = wb_data;
            default: value = rd;
        endcase
        return value;
    endfunction

    assign rs1_sel = fwd_pick(id_rs1);
    assign rs2_sel = fwd_pick(id_rs2);
    assign op_a    = fwd_value(rs1_sel, id_rs1_data);
    assign rs2_val = fwd_value(rs2_sel, id_rs2_data);
    assign op_b    = (id_op inside {op_addi, op_lw, op_sw}) ? id_imm : rs2_val;

    // loads and stores use the adder for their address.
    always_comb begin
        case (id_op)
            op_add, op_addi, op_lw, op_sw: alu_result = op_a + op_b;
            op_sub:                        alu_result = op_a - op_b;
            op_and:                        alu_result = op_a & op_b;
            op_or:                         alu_result = op_a | op_b;
            default:                       alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_op         <= id_op;
        ex_rd         <= id_rd;
        ex_result     <= alu_result;
        ex_store_data <= rs2_val;
    end

endmodule

`default_nettype wire

/* hw/memory_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_stage
    import rv_pkg::*;
#(
    parameter int dmem_depth = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ex_valid,
    input  op_e             ex_op,
    input  reg_addr_t       ex_rd,
    input  logic [xlen-1:0] ex_result,
    input  logic [xlen-1:0] ex_store_data,
    output logic            wb_valid,
    output reg_addr_t       wb_rd,
    output logic [xlen-1:0] wb_data,
    output logic            done
);

    localparam int aw = $clog2(dmem_depth);

    logic [xlen-1:0] dmem [dmem_depth];
    logic [aw-1:0]   addr;
    logic [xlen-1:0] wb_next;

    // word addressed; the two low byte bits are dropped.
    assign addr = ex_result[aw+1:2];

    always_ff @(posedge clk) begin
        if (ex_valid && ex_op == op_sw) begin
            dmem[addr] <= ex_store_data;
        end
    end

    always_comb begin
        if (ex_op == op_sw) begin
            wb_next = ex_store_data;
        end else if (ex_rd == '0) begin
            wb_next = '0;
        end else if (ex_op == op_lw) begin
            wb_next = dmem[addr];
        end else begin
            wb_next = ex_result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            if (ex_valid && ex_op == op_ebreak) begin
                done <= 1'b1;
            end
        end
    end

    // stores already arrive with rd zero from decode.
    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= wb_next;
    end

endmodule

`default_nettype wire

/* hw/core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_top
    import rv_pkg::*;
#(
    parameter int imem_depth = 64,
    parameter int dmem_depth = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load_en,
    input  logic [$clog2(imem_depth)-1:0] load_addr,
    input  logic [xlen-1:0]               load_data,
    input  logic                          run,
    output logic                          retire_valid,
    output reg_addr_t                     retire_rd,
    output logic [xlen-1:0]               retire_data,
    output logic                          done
);

    logic            stall;
    logic            halt;
    logic            if_valid;
    logic [xlen-1:0] if_instr;
    logic            id_valid;
    op_e             id_op;
    reg_addr_t       id_rd;
    reg_addr_t       id_rs1;
    reg_addr_t       id_rs2;
    logic [xlen-1:0] id_rs1_data;
    logic [xlen-1:0] id_rs2_data;
    logic [xlen-1:0] id_imm;
    logic            ex_valid;
    op_e             ex_op;
    reg_addr_t       ex_rd;
    logic [xlen-1:0] ex_result;
    logic [xlen-1:0] ex_store_data;
    logic            wb_valid;
    reg_addr_t       wb_rd;
    logic [xlen-1:0] wb_data;

    fetch_stage #(
        .imem_depth (imem_depth)
    ) i_fetch_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .run       (run),
        .stall     (stall),
        .halt      (halt),
        .if_valid  (if_valid),
        .if_instr  (if_instr)
    );

    decode_stage i_decode_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .if_valid    (if_valid),
        .if_instr    (if_instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .stall       (stall),
        .halt        (halt),
        .id_valid    (id_valid),
        .id_op       (id_op),
        .id_rd       (id_rd),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_rs1_data (id_rs1_data),
        .id_rs2_data (id_rs2_data),
        .id_imm      (id_imm)
    );

    execute_stage i_execute_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_valid      (id_valid),
        .id_op         (id_op),
        .id_rd         (id_rd),
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .id_rs1_data   (id_rs1_data),
        .id_rs2_data   (id_rs2_data),
        .id_imm        (id_imm),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data)
    );

    memory_stage #(
        .dmem_depth (dmem_depth)
    ) i_memory_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .done          (done)
    );

    // writeback doubles as the retire port.
    assign retire_valid = wb_valid;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire

/* testbench/core_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module core_chk
    import rv_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      stall,
    input fwd_e      rs1_sel,
    input fwd_e      rs2_sel,
    input reg_addr_t id_rs1,
    input reg_addr_t id_rs2,
    input logic      done
);

    // the bubble behind a load clears the hazard, so a stall lasts one cycle.
    assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
        else $error("stall stayed high for two cycles");

    assert property (@(posedge clk) disable iff (!rst_n) rs1_sel != fwd_reg |-> id_rs1 != '0)
        else $error("operand a was forwarded for x0");

    assert property (@(posedge clk) disable iff (!rst_n) rs2_sel != fwd_reg |-> id_rs2 != '0)
        else $error("operand b was forwarded for x0");

    assert property (@(posedge clk) disable iff (!rst_n) done |=> done)
        else $error("done fell after it had risen");

endmodule

bind decode_stage core_chk i_core_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .stall   (stall),
    .rs1_sel (rv_pkg::fwd_reg),
    .rs2_sel (rv_pkg::fwd_reg),
    .id_rs1  (5'd0),
    .id_rs2  (5'd0),
    .done    (1'b0)
);

bind execute_stage core_chk i_core_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .stall   (1'b0),
    .rs1_sel (rs1_sel),
    .rs2_sel (rs2_sel),
    .id_rs1  (id_rs1),
    .id_rs2  (id_rs2),
    .done    (1'b0)
);

// done is produced by the memory stage.
bind memory_stage core_chk i_core_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .stall   (1'b0),
    .rs1_sel (rv_pkg::fwd_reg),
    .rs2_sel (rv_pkg::fwd_reg),
    .id_rs1  (5'd0),
    .id_rs2  (5'd0),
    .done    (done)
);

`default_nettype wire

/* testbench/core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module core_tb;

    localparam int imem_depth = 64;
    localparam int dmem_depth = 64;
    // program lengths over all tests are 8 + 9 + 9 + 10 + 8 + 41.
    localparam int total_instrs = 85;
    localparam int watchdog_cycles = 30 * total_instrs;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    logic                          clk;
    logic                          rst_n;
    logic                          load_en;
    logic [$clog2(imem_depth)-1:0] load_addr;
    logic [31:0]                   load_data;
    logic                          run;
    logic                          retire_valid;
    logic [4:0]                    retire_rd;
    logic [31:0]                   retire_data;
    logic                          done;

    int          errors;
    int          seed;
    logic [31:0] prog [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [dmem_depth];

    core_top #(
        .imem_depth (imem_depth),
        .dmem_depth (dmem_depth)
    ) i_core_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .run          (run),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("errors: %0d", errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] add_w(input int rd, input int rs1, input int rs2);
        return {7'h00, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] sub_w(input int rd, input int rs1, input int rs2);
        return {7'h20, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] and_w(input int rd, input int rs1, input int rs2);
        return {7'h00, rs2[4:0], rs1[4:0], 3'b111, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] or_w(input int rd, input int rs1, input int rs2);
        return {7'h00, rs2[4:0], rs1[4:0], 3'b110, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_w(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] lw_w(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_w(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %h got %h", $time, what, expected, actual);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // architectural model of the subset; it lists the retirements in program order.
    task automatic interpret();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] value;
        logic [4:0]  rd;
        exp_rd.delete();
        exp_data.delete();
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        foreach (prog[i]) begin
            w     = prog[i];
            rd    = w[11:7];
            a     = model_regs[w[19:15]];
            b     = model_regs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            value = '0;
            if (w == ebreak_word) begin
                exp_rd.push_back('0);
                exp_data.push_back('0);
                break;
            end
            case (w[6:0])
                7'b0110011: begin
                    case ({w[30], w[14:12]})
                        4'b0000: value = a + b;
                        4'b1000: value = a - b;
                        4'b0111: value = a & b;
                        default: value = a | b;
                    endcase
                end
                7'b0010011: value = a + imm_i;
                7'b0000011: begin
                    addr  = a + imm_i;
                    value = model_mem[addr[7:2]];
                end
                default: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    model_mem[addr[7:2]] = b;
                end
            endcase
            if (w[6:0] == 7'b0100011) begin
                exp_rd.push_back('0);
                exp_data.push_back(b);
            end else if (rd == '0) begin
                exp_rd.push_back('0);
                exp_data.push_back('0);
            end else begin
                model_regs[rd] = value;
                exp_rd.push_back(rd);
                exp_data.push_back(value);
            end
        end
    endtask

    task automatic run_program(input string name);
        int          cycles;
        int          limit;
        logic [4:0]  rd_e;
        logic [31:0] data_e;
        apply_reset();
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = i[$clog2(imem_depth)-1:0];
            load_data = prog[i];
        end
        @(negedge clk);
        load_en = 1'b0;
        interpret();
        run    = 1'b1;
        limit  = 20 * prog.size();
        cycles = 0;
        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (retire_valid) begin
                if (exp_rd.size() == 0) begin
                    errors++;
                    $display("%s: extra retirement at %0t ns after the program ended", name, $time);
                end else begin
                    rd_e   = exp_rd.pop_front();
                    data_e = exp_data.pop_front();
                    check(32'(retire_rd), 32'(rd_e), {name, " retire rd"});
                    check(retire_data, data_e, {name, " retire data"});
                    // done rises together with the last retirement, which is EBREAK.
                    check(32'(done), 32'(exp_rd.size() == 0), {name, " done"});
                end
            end
        end
        if (!done) begin
            errors++;
            $display("%s: done did not rise within %0d cycles", name, limit);
        end
        if (exp_rd.size() != 0) begin
            errors++;
            $display("%s: %0d expected retirements never appeared", name, exp_rd.size());
        end
        for (int r = 1; r < 32; r++) begin
            check(i_core_top.i_decode_stage.i_reg_file.regs[r], model_regs[r],
                  $sformatf("%s final x%0d", name, r));
        end
        @(negedge clk);
        run = 1'b0;
        prog.delete();
    endtask

    task automatic chain_test();
        prog.push_back(addi_w(1, 0, 21));
        prog.push_back(addi_w(2, 1, -5));
        prog.push_back(add_w(3, 1, 2));
        prog.push_back(sub_w(4, 3, 1));
        prog.push_back(and_w(5, 4, 3));
        prog.push_back(or_w(6, 5, 2));
        prog.push_back(sub_w(7, 6, 4));
        prog.push_back(ebreak_word);
        run_program("chain");
    endtask

    task automatic distance_test();
        prog.push_back(addi_w(1, 0, 100));
        prog.push_back(addi_w(2, 0, 7));
        prog.push_back(addi_w(3, 0, -3));
        prog.push_back(add_w(4, 1, 2));
        prog.push_back(addi_w(9, 0, 1));
        prog.push_back(or_w(5, 4, 3));
        prog.push_back(and_w(6, 4, 9));
        prog.push_back(sub_w(7, 5, 6));
        prog.push_back(ebreak_word);
        run_program("distance");
    endtask

    task automatic store_load_test();
        prog.push_back(addi_w(1, 0, 'h55));
        prog.push_back(addi_w(2, 0, 16));
        prog.push_back(sw_w(1, 2, 4));
        prog.push_back(lw_w(3, 2, 4));
        prog.push_back(addi_w(4, 0, 1));
        prog.push_back(add_w(5, 3, 4));
        prog.push_back(sw_w(5, 2, -8));
        prog.push_back(lw_w(6, 0, 8));
        prog.push_back(ebreak_word);
        run_program("store_load");
    endtask

    // each load is followed at once by a consumer, so every pair costs a bubble.
    task automatic load_use_test();
        prog.push_back(addi_w(1, 0, 40));
        prog.push_back(addi_w(2, 0, -77));
        prog.push_back(sw_w(2, 1, 0));
        prog.push_back(lw_w(3, 1, 0));
        prog.push_back(add_w(4, 3, 3));
        prog.push_back(lw_w(5, 1, 0));
        prog.push_back(sw_w(5, 1, 4));
        prog.push_back(lw_w(6, 1, 4));
        prog.push_back(addi_w(7, 6, 3));
        prog.push_back(ebreak_word);
        run_program("load_use");
    endtask

    task automatic x0_test();
        prog.push_back(addi_w(0, 0, 5));
        prog.push_back(addi_w(1, 0, 9));
        prog.push_back(add_w(0, 1, 1));
        prog.push_back(add_w(2, 0, 1));
        prog.push_back(sub_w(3, 0, 0));
        prog.push_back(or_w(0, 1, 2));
        prog.push_back(and_w(4, 0, 1));
        prog.push_back(ebreak_word);
        run_program("x0");
    endtask

    task automatic random_test();
        logic [31:0] r;
        int          kind;
        for (int i = 0; i < 40; i++) begin
            r    = $random(seed);
            kind = int'(r[31:16] % 16'd3);
            case (kind)
                0:       prog.push_back(add_w(int'(r[2:0]), int'(r[5:3]), int'(r[8:6])));
                1:       prog.push_back(sub_w(int'(r[2:0]), int'(r[5:3]), int'(r[8:6])));
                default: prog.push_back(addi_w(int'(r[2:0]), int'(r[5:3]), int'(r[20:9])));
            endcase
        end
        prog.push_back(ebreak_word);
        run_program("random");
    endtask

    initial begin
        seed      = 77433;
        errors    = 0;
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        run       = 1'b0;
        chain_test();
        distance_test();
        store_load_test();
        load_use_test();
        x0_test();
        random_test();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hw/rv_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/core_top.sv
testbench/core_chk.sv
testbench/core_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := core_tb
FILELIST := src.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
